/* Bender.yml */
package:
  name: pulse_gen

sources:
  - pulse_gen_pkg.sv
  - pulse_regs.sv
  - pulse_tick.sv
  - pulse_shaper.sv
  - pulse_gen_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_pulse_gen.sv

/* pulse_gen_pkg.sv */
package pulse_gen_pkg;

    // ########################################################################
    // Widths
    // ########################################################################

    localparam int addr_w   = 16;                   // Wishbone byte address
    localparam int data_w   = 32;                   // Wishbone data bus
    localparam int period_w = 32;                   // Ticks per period
    localparam int shift_w  = 4;                    // Prescaler exponent
    localparam int mode_w   = 3;
    localparam int width_w  = 8;                    // Pulse high time in ticks
    localparam int count_w  = 16;                   // Emitted pulse counter

    // Prescaler counter must reach 2**15 - 1
    localparam int presc_w  = 2**shift_w - 1;

    localparam int cmd_trig_bit = 0;                // Trigger bit in reg_cmd

    // ########################################################################
    // Encodings
    // ########################################################################

    typedef enum logic [addr_w-1:0] {
        reg_period = 16'h0000,
        reg_ctrl   = 16'h0004,
        reg_status = 16'h0008,                      // Read only
        reg_cmd    = 16'h000C                       // Write only, reads zero
    } pg_addr_e;

    // Codes 3 to 7 reserved, treated as off
    typedef enum logic [mode_w-1:0] {
        mode_off        = 3'd0,
        mode_single     = 3'd1,
        mode_continuous = 3'd2
    } pg_mode_e;

    // ########################################################################
    // Bundles
    // ########################################################################

    // Master to slave
    typedef struct packed {
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat;
        logic              we;
        logic              stb;
        logic              cyc;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [data_w-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    // Register bank to both pipeline stages
    typedef struct packed {
        logic [period_w-1:0] period;                // reg_period
        logic [width_w-1:0]  width;                 // ctrl[15:8]
        logic                enable;                // ctrl[7]
        pg_mode_e            mode;                  // ctrl[6:4]
        logic [shift_w-1:0]  shift;                 // ctrl[3:0]
    } pg_cfg_t;

    // Shaper back to register bank
    typedef struct packed {
        logic               busy;                   // status[16]
        logic [count_w-1:0] count;                  // status[15:0]
    } pg_status_t;

endpackage

/* pulse_gen_top.sv */
module pulse_gen_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pulse_gen_pkg::wb_req_t wb_req,
    output pulse_gen_pkg::wb_rsp_t wb_rsp,
    output logic                   pulse_out
);

    pulse_gen_pkg::pg_cfg_t    cfg;
    pulse_gen_pkg::pg_status_t status;
    logic                      trigger;
    logic                      tick;

    // ########################################################################
    // Register bank
    // ########################################################################

    pulse_regs pulse_regs_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .status  (status),
        .cfg     (cfg),
        .trigger (trigger)
    );

    // ########################################################################
    // Pipeline stages
    // ########################################################################

    pulse_tick pulse_tick_i (
        .clk    (clk),
        .arst_n (arst_n),
        .cfg    (cfg),
        .tick   (tick)                              // Timebase to shaper
    );

    pulse_shaper pulse_shaper_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .tick      (tick),
        .trigger   (trigger),
        .status    (status),                        // Back to reg_status
        .pulse_out (pulse_out)
    );

endmodule

/* pulse_regs.sv */
module pulse_regs (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pulse_gen_pkg::wb_req_t  wb_req,
    output pulse_gen_pkg::wb_rsp_t  wb_rsp,
    input  pulse_gen_pkg::pg_status_t status,
    output pulse_gen_pkg::pg_cfg_t  cfg,
    output logic                    trigger
);

    pulse_gen_pkg::pg_cfg_t               cfg_q;
    logic                                 ack_q;
    logic                                 trigger_q;
    logic [pulse_gen_pkg::data_w-1:0]     rdata_d;
    logic [pulse_gen_pkg::data_w-1:0]     rdata_q;
    logic                                 accept;
    logic                                 wr_en;

    // ########################################################################
    // Bus handshake
    // ########################################################################

    // A request is never taken again on its own ack cycle
    assign accept = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_en  = accept && wb_req.we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;                        // Fixed one clock latency
        end
    end

    // ########################################################################
    // Write side
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q     <= '0;
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= 1'b0;                      // Self clearing
            if (wr_en) begin
                case (wb_req.adr)
                    pulse_gen_pkg::reg_period: begin
                        cfg_q.period <= wb_req.dat;
                    end
                    pulse_gen_pkg::reg_ctrl: begin
                        cfg_q.shift  <= wb_req.dat[3:0];
                        cfg_q.mode   <= pulse_gen_pkg::pg_mode_e'(wb_req.dat[6:4]);
                        cfg_q.enable <= wb_req.dat[7];
                        cfg_q.width  <= wb_req.dat[15:8];
                    end
                    pulse_gen_pkg::reg_cmd: begin
                        trigger_q <= wb_req.dat[pulse_gen_pkg::cmd_trig_bit];
                    end
                    default: begin
                        // Status and unmapped writes are dropped
                    end
                endcase
            end
        end
    end

    // ########################################################################
    // Read side
    // ########################################################################

    always_comb begin
        rdata_d = '0;
        case (wb_req.adr)
            pulse_gen_pkg::reg_period: begin
                rdata_d = cfg_q.period;
            end
            pulse_gen_pkg::reg_ctrl: begin
                rdata_d[15:0] = {cfg_q.width, cfg_q.enable, cfg_q.mode, cfg_q.shift};
            end
            pulse_gen_pkg::reg_status: begin
                rdata_d[16:0] = {status.busy, status.count};
            end
            default: begin
                rdata_d = '0;                       // reg_cmd and holes
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (accept) begin
            rdata_q <= rdata_d;                     // Held through the ack cycle
        end
    end

    assign wb_rsp.dat = rdata_q;
    assign wb_rsp.ack = ack_q;
    assign cfg        = cfg_q;
    assign trigger    = trigger_q;

    // Ack only answers a request seen on the previous edge
    ack_follows_req : assert property (
        @(posedge clk) disable iff (!arst_n)
        ack_q |-> $past(wb_req.cyc && wb_req.stb)
    );

    ack_single_clock : assert property (
        @(posedge clk) disable iff (!arst_n)
        ack_q |=> !ack_q
    );

endmodule

/* pulse_shaper.sv */
module pulse_shaper (
    input  logic                       clk,
    input  logic                       arst_n,
    input  pulse_gen_pkg::pg_cfg_t     cfg,
    input  logic                       tick,
    input  logic                       trigger,
    output pulse_gen_pkg::pg_status_t  status,
    output logic                       pulse_out
);

    pulse_gen_pkg::pg_mode_e                mode_q;
    logic [pulse_gen_pkg::period_w-1:0]     tick_cnt_q;
    logic [pulse_gen_pkg::period_w-1:0]     next_cnt;
    logic [pulse_gen_pkg::period_w-1:0]     last_tick;
    logic [pulse_gen_pkg::count_w-1:0]      count_q;
    logic                                   busy_q;
    logic                                   pend_q;
    logic                                   pulse_q;
    logic                                   is_single;
    logic                                   is_cont;
    logic                                   stop;
    logic                                   wrap;
    logic                                   start;

    // ########################################################################
    // Mode decode and period control
    // ########################################################################

    assign is_single = cfg.enable && (cfg.mode == pulse_gen_pkg::mode_single);
    assign is_cont   = cfg.enable && (cfg.mode == pulse_gen_pkg::mode_continuous);

    // Reserved codes fall out here as well
    assign stop = !(is_single || is_cont) || (cfg.mode != mode_q);

    // Period of zero runs as one tick
    assign last_tick = (cfg.period == '0) ? '0 : cfg.period - 1'b1;
    assign next_cnt  = tick_cnt_q + 1'b1;

    assign wrap  = busy_q && tick && (tick_cnt_q >= last_tick);
    assign start = tick && ((!busy_q && (is_cont || pend_q)) || (wrap && is_cont));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q     <= pulse_gen_pkg::mode_off;
            tick_cnt_q <= '0;
            count_q    <= '0;
            busy_q     <= 1'b0;
            pend_q     <= 1'b0;
            pulse_q    <= 1'b0;
        end else begin
            mode_q <= cfg.mode;
            if (stop) begin
                busy_q     <= 1'b0;
                pend_q     <= 1'b0;
                pulse_q    <= 1'b0;
                tick_cnt_q <= '0;
            end else begin
                if (trigger && is_single && !busy_q) begin
                    pend_q <= 1'b1;                 // Waits for next tick
                end
                if (start) begin
                    busy_q     <= 1'b1;
                    pend_q     <= 1'b0;
                    tick_cnt_q <= '0;
                    pulse_q    <= (cfg.width != '0);
                    count_q    <= count_q + 1'b1;   // Wraps at 16 bits
                end else if (wrap) begin
                    busy_q     <= 1'b0;             // Single shot done
                    pulse_q    <= 1'b0;
                    tick_cnt_q <= '0;
                end else if (busy_q && tick) begin
                    tick_cnt_q <= next_cnt;
                    pulse_q    <= (next_cnt < pulse_gen_pkg::period_w'(cfg.width));
                end
            end
        end
    end

    assign status.count = count_q;
    assign status.busy  = busy_q;
    assign pulse_out    = pulse_q;

    // Output must be gone one clock after enable drops
    pulse_off_when_disabled : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$past(cfg.enable) |-> !pulse_out
    );

endmodule

/* pulse_tick.sv */
module pulse_tick (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pulse_gen_pkg::pg_cfg_t cfg,
    output logic                   tick
);

    logic [pulse_gen_pkg::presc_w-1:0] cnt_q;
    logic [pulse_gen_pkg::presc_w-1:0] limit;
    logic                              tick_q;
    logic                              at_limit;

    // Terminal count is 2**shift - 1, low shift bits set
    assign limit = ~({pulse_gen_pkg::presc_w{1'b1}} << cfg.shift);

    // >= covers a shift lowered while the counter is above the new limit
    assign at_limit = (cnt_q >= limit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (!cfg.enable) begin
            cnt_q  <= '0;                           // Timebase restarts on enable
            tick_q <= 1'b0;
        end else begin
            tick_q <= at_limit;
            if (at_limit) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign tick = tick_q;

endmodule

/* sources.f */
pulse_gen_pkg.sv
pulse_regs.sv
pulse_tick.sv
pulse_shaper.sv
pulse_gen_top.sv
tb_clock.sv
tb_pulse_gen.sv

/* tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int half_period  = 5;                // 10 time unit clock
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;                              // Released off the edge
    end

endmodule

/* tb_pulse_gen.sv */
module tb_pulse_gen;

    localparam int drive_delay = 1;                 // After the rising edge
    localparam int ack_limit   = 8;

    typedef enum {op_write, op_read, op_status, op_measure, op_measure_min} op_e;

    // For measures data holds the window in clocks and exp the high time or 0 to skip it
    typedef struct {
        op_e                              op;
        logic [pulse_gen_pkg::addr_w-1:0] addr;
        logic [pulse_gen_pkg::data_w-1:0] data;
        logic [pulse_gen_pkg::data_w-1:0] exp;
        int                               cnt;
    } step_t;

    logic                   clk;
    logic                   arst_n;
    pulse_gen_pkg::wb_req_t wb_req;
    pulse_gen_pkg::wb_rsp_t wb_rsp;
    logic                   pulse_out;

    int          seed        = 44;
    int          errors      = 0;
    int          tests       = 0;
    int          failed      = 0;
    int          rise_total  = 0;
    int          high_clocks = 0;
    logic        pulse_prev  = 1'b0;
    longint      watchdog_time = 0;
    int unsigned high_times[$];
    step_t       steps[$];

    tb_clock tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pulse_gen_top pulse_gen_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .pulse_out (pulse_out)
    );

    // ########################################################################
    // Pulse monitor sampled on the falling edge
    // ########################################################################

    always @(negedge clk) begin
        if (pulse_out && !pulse_prev) begin
            rise_total  = rise_total + 1;
            high_clocks = 1;
        end else if (pulse_out) begin
            high_clocks = high_clocks + 1;
        end else if (pulse_prev) begin
            high_times.push_back(high_clocks);      // Completed pulse
        end
        pulse_prev = pulse_out;
    end

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_rsp(input pulse_gen_pkg::wb_rsp_t got,
                             input pulse_gen_pkg::wb_rsp_t exp);
        if (got.dat !== exp.dat) begin
            $display("Error wb_rsp.dat: got 0x%0h, expected 0x%0h", got.dat, exp.dat);
            errors++;
        end
        if (got.ack !== exp.ack) begin
            $display("Error wb_rsp.ack: got 0x%0h, expected 0x%0h", got.ack, exp.ack);
            errors++;
        end
    endtask

    task automatic check_status(input pulse_gen_pkg::pg_status_t got,
                                input pulse_gen_pkg::pg_status_t exp);
        if (got.count !== exp.count) begin
            $display("Error status.count: got 0x%0h, expected 0x%0h", got.count, exp.count);
            errors++;
        end
        if (got.busy !== exp.busy) begin
            $display("Error status.busy: got 0x%0h, expected 0x%0h", got.busy, exp.busy);
            errors++;
        end
    endtask

    task automatic check_pulse(input string name,
                               input logic [pulse_gen_pkg::period_w-1:0] got,
                               input logic [pulse_gen_pkg::period_w-1:0] exp,
                               input bit at_least);
        bit ok;
        ok = at_least ? (got >= exp) : (got === exp);
        if (!ok) begin
            $display("Error %s: got 0x%0h, expected %s0x%0h", name, got,
                     at_least ? "at least " : "", exp);
            errors++;
        end
    endtask

    // ########################################################################
    // Wishbone driver and pulse measurement
    // ########################################################################

    task automatic bus_access(input logic [pulse_gen_pkg::addr_w-1:0] adr,
                              input logic [pulse_gen_pkg::data_w-1:0] dat,
                              input logic we,
                              output pulse_gen_pkg::wb_rsp_t rsp);
        int waited;
        @(posedge clk);
        #drive_delay;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.we  = we;
        wb_req.stb = 1'b1;
        wb_req.cyc = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #drive_delay;
            waited++;
        end while (!wb_rsp.ack && waited < ack_limit);
        rsp = wb_rsp;
        if (!wb_rsp.ack) begin
            $display("Access to address 0x%0h was never acknowledged", adr);
            errors++;
        end else begin
            check_pulse("ack latency", waited, 1, 1'b0);
        end
        wb_req.stb = 1'b0;                          // Dropped on the ack cycle
        wb_req.cyc = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic measure_pulses(input step_t s);
        int rises_start;
        int rises;
        @(posedge clk);                             // Output settles within one clock
        #drive_delay;
        high_times.delete();
        rises_start = rise_total;
        repeat (s.data - 1) @(posedge clk);
        #drive_delay;
        rises = rise_total - rises_start;
        if (s.exp != 0) begin
            if (high_times.size() == 0) begin
                $display("No complete pulse was seen in the measure window");
                errors++;
            end
            foreach (high_times[i]) begin
                check_pulse("pulse_out high clocks", high_times[i], s.exp, 1'b0);
            end
        end
        check_pulse("pulse_out count", rises, s.cnt, s.op == op_measure_min);
        if (s.cnt == 0) begin
            check_pulse("pulse_out", pulse_out, 0, 1'b0);
        end
    endtask

    // ########################################################################
    // Stimulus table
    // ########################################################################

    function automatic logic [31:0] ctrl_word(input logic [7:0] width, input logic enable,
                                              input logic [2:0] mode, input logic [3:0] shift);
        return {16'h0000, width, enable, mode, shift};
    endfunction

    task automatic add_step(input op_e op, input logic [15:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input int cnt);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        s.cnt  = cnt;
        steps.push_back(s);
    endtask

    task automatic build_steps();
        logic [31:0] per_a;
        logic [31:0] per_b;
        per_a = ($random(seed) & 32'h7) + 32'd4;   // Always above the widths used
        per_b = ($random(seed) & 32'h7) + 32'd4;
        // Reset state
        add_step(op_read, pulse_gen_pkg::reg_period, 0, 0, 0);
        add_step(op_read, pulse_gen_pkg::reg_ctrl, 0, 0, 0);
        add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
        add_step(op_read, pulse_gen_pkg::reg_cmd, 0, 0, 0);
        add_step(op_measure, 0, 20, 0, 0);
        // Readback
        add_step(op_write, pulse_gen_pkg::reg_period, per_a, 0, 0);
        add_step(op_read, pulse_gen_pkg::reg_period, 0, per_a, 0);
        add_step(op_write, pulse_gen_pkg::reg_ctrl, 32'hABCD_1234, 0, 0);
        add_step(op_read, pulse_gen_pkg::reg_ctrl, 0, 32'h0000_1234, 0);
        add_step(op_write, pulse_gen_pkg::reg_cmd, 32'h1, 0, 0);
        add_step(op_read, pulse_gen_pkg::reg_cmd, 0, 0, 0);
        add_step(op_write, pulse_gen_pkg::reg_status, 32'hFFFF_FFFF, 0, 0);
        add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
        add_step(op_write, 16'h0010, 32'hDEAD_BEEF, 0, 0);
        add_step(op_read, 16'h0010, 0, 0, 0);
        // Two single shots of 3 ticks at 2 clocks per tick
        add_step(op_write, pulse_gen_pkg::reg_ctrl,
                 ctrl_word(8'd3, 1'b1, pulse_gen_pkg::mode_single, 4'd1), 0, 0);
        for (int i = 0; i < 2; i++) begin
            add_step(op_write, pulse_gen_pkg::reg_cmd, 32'h1, 0, 0);
            add_step(op_measure, 0, 80, 32'd3 << 1, 1);
            add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
        end
        // Continuous pulses of 2 ticks at 4 clocks per tick
        add_step(op_write, pulse_gen_pkg::reg_ctrl,
                 ctrl_word(8'd2, 1'b1, pulse_gen_pkg::mode_continuous, 4'd2), 0, 0);
        add_step(op_measure_min, 0, 240, 32'd2 << 2, 4);
        add_step(op_write, pulse_gen_pkg::reg_ctrl,
                 ctrl_word(8'd2, 1'b0, pulse_gen_pkg::mode_continuous, 4'd2), 0, 0);
        add_step(op_measure, 0, 60, 0, 0);
        add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
        // Width beyond the period holds the output for the whole period
        add_step(op_write, pulse_gen_pkg::reg_period, per_b, 0, 0);
        add_step(op_write, pulse_gen_pkg::reg_ctrl,
                 ctrl_word(8'hFF, 1'b1, pulse_gen_pkg::mode_single, 4'd1), 0, 0);
        add_step(op_write, pulse_gen_pkg::reg_cmd, 32'h1, 0, 0);
        add_step(op_measure, 0, 80, per_b << 1, 1);
        add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
        // Reserved mode code
        add_step(op_write, pulse_gen_pkg::reg_ctrl, ctrl_word(8'd2, 1'b1, 3'd5, 4'd0), 0, 0);
        add_step(op_write, pulse_gen_pkg::reg_cmd, 32'h1, 0, 0);
        add_step(op_measure, 0, 60, 0, 0);
        add_step(op_status, pulse_gen_pkg::reg_status, 0, 0, 0);
    endtask

    task automatic run_step(input int idx, input step_t s);
        pulse_gen_pkg::wb_rsp_t    rsp;
        pulse_gen_pkg::wb_rsp_t    exp_rsp;
        pulse_gen_pkg::pg_status_t exp_status;
        int                        errors_before;
        errors_before = errors;
        case (s.op)
            op_write: begin
                bus_access(s.addr, s.data, 1'b1, rsp);
            end
            op_read: begin
                bus_access(s.addr, '0, 1'b0, rsp);
                exp_rsp.dat = s.exp;
                exp_rsp.ack = 1'b1;
                check_rsp(rsp, exp_rsp);
            end
            op_status: begin
                bus_access(s.addr, '0, 1'b0, rsp);
                exp_status.count = pulse_gen_pkg::count_w'(rise_total);
                exp_status.busy  = s.exp[16];
                check_status(pulse_gen_pkg::pg_status_t'(rsp.dat[16:0]), exp_status);
                check_pulse("wb_rsp.dat[31:17]", rsp.dat[31:17], 0, 1'b0);
            end
            default: begin
                measure_pulses(s);
            end
        endcase
        tests++;
        if (errors != errors_before) begin
            failed++;
        end
        $display("Test %0d %s addr 0x%0h: %s", idx, s.op.name(), s.addr,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    // ########################################################################
    // Main sequence and watchdog
    // ########################################################################

    initial begin
        longint clocks;
        wb_req = '0;
        build_steps();
        clocks = 100;
        foreach (steps[i]) begin
            clocks += 12;
            if (steps[i].op == op_measure || steps[i].op == op_measure_min) begin
                clocks += steps[i].data;
            end
        end
        watchdog_time = clocks * 10;
        wait (arst_n === 1'b1);
        foreach (steps[i]) begin
            run_step(i, steps[i]);
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (watchdog_time != 0);
        #(watchdog_time);
        $display("Watchdog expired after %0d time units, the run did not finish",
                 watchdog_time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
